/* zx_dram.f */
source/zx_dram_pkg.sv
source/dram_arbiter.sv
source/dram_sequencer.sv
source/zx_dram_top.sv
testbench/dram_model.sv
testbench/zx_dram_tb.sv

/* Makefile */
TOP := zx_dram_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f zx_dram.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* testbench/zx_dram_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module zx_dram_tb
    import zx_dram_pkg::*;
();

    localparam int RA_W    = 10;
    localparam int RA2     = 2*RA_W;
    localparam int WA      = 2*RA_W + 1;
    localparam int POOL_N  = 16;
    localparam int RAND_N  = 300;
    localparam int REQ_N   = POOL_N + 2 + 5 + 3 + RAND_N;
    localparam int TIMEOUT = REQ_N*12 + 200;
    localparam int VID     = 0;
    localparam int CPU     = 1;
    localparam int DMA     = 2;

    logic                fclk;
    logic                rst;
    logic                video_valid;
    logic [WA-1:0]       video_addr;
    logic                video_ready;
    logic                video_rvalid;
    logic [DATA_W-1:0]   video_rdata;
    logic                cpu_valid;
    dram_op_t            cpu_op;
    logic [WA:0]         cpu_addr;
    logic [BYTE_W-1:0]   cpu_wdata;
    logic                cpu_ready;
    logic                cpu_rvalid;
    logic [BYTE_W-1:0]   cpu_rdata;
    logic                dma_valid;
    dram_op_t            dma_op;
    logic [WA-1:0]       dma_addr;
    logic [DATA_W-1:0]   dma_wdata;
    logic                dma_ready;
    logic                dma_rvalid;
    logic [DATA_W-1:0]   dma_rdata;
    logic [RA_W-1:0]     ra;
    logic [DATA_W-1:0]   dram_wd;
    logic [DATA_W-1:0]   dram_rd;
    logic                rwe_n;
    logic                rucas_n;
    logic                rlcas_n;
    logic                rras0_n;
    logic                rras1_n;

    logic [2:0]          readies;
    logic [2:0]          rvalids;
    logic [DATA_W-1:0]   rdatas [3];
    logic [DATA_W-1:0]   shadow [logic [WA-1:0]];
    logic [WA-1:0]       pool [POOL_N];
    logic [DATA_W-1:0]   exp_q [3][$];
    int                  t_q [3][$];
    int                  grant_log [$];
    int                  grant_cyc [$];
    string               names [3] = '{"video", "cpu", "dma"};
    string               test_name = "none";
    int                  cycle = 0;
    int                  checks = 0;
    int                  errors = 0;
    int                  stim_errors = 0;

    zx_dram_top UUT (
        .fclk(fclk), .rst(rst),
        .video_valid(video_valid), .video_addr(video_addr), .video_ready(video_ready),
        .video_rvalid(video_rvalid), .video_rdata(video_rdata),
        .cpu_valid(cpu_valid), .cpu_op(cpu_op), .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
        .cpu_ready(cpu_ready), .cpu_rvalid(cpu_rvalid), .cpu_rdata(cpu_rdata),
        .dma_valid(dma_valid), .dma_op(dma_op), .dma_addr(dma_addr), .dma_wdata(dma_wdata),
        .dma_ready(dma_ready), .dma_rvalid(dma_rvalid), .dma_rdata(dma_rdata),
        .ra(ra), .dram_wd(dram_wd), .dram_rd(dram_rd), .rwe_n(rwe_n),
        .rucas_n(rucas_n), .rlcas_n(rlcas_n), .rras0_n(rras0_n), .rras1_n(rras1_n)
    );

    dram_model #(
        .RA_W(RA_W)
    ) memory (
        .fclk(fclk), .ra(ra), .dram_wd(dram_wd), .dram_rd(dram_rd), .rwe_n(rwe_n),
        .rucas_n(rucas_n), .rlcas_n(rlcas_n), .rras0_n(rras0_n), .rras1_n(rras1_n)
    );

    assign readies     = {dma_ready, cpu_ready, video_ready};
    assign rvalids     = {dma_rvalid, cpu_rvalid, video_rvalid};
    assign rdatas[VID] = video_rdata;
    assign rdatas[CPU] = {{(DATA_W-BYTE_W){1'b0}}, cpu_rdata};
    assign rdatas[DMA] = dma_rdata;

    initial fclk = 1'b0;
    always #5 fclk = ~fclk;

    // expected word is the last value written to that address
    function automatic logic [DATA_W-1:0] ref_word(input logic [WA-1:0] addr);
        return shadow[addr];
    endfunction

    // odd byte address selects the upper half
    function automatic logic [BYTE_W-1:0] ref_byte(input logic [WA:0] baddr);
        logic [DATA_W-1:0] w;
        w = shadow[baddr[WA:1]];
        return baddr[0] ? w[DATA_W-1:BYTE_W] : w[BYTE_W-1:0];
    endfunction

    task automatic check_return(input int who, input logic [DATA_W-1:0] act);
        logic [DATA_W-1:0] e;
        int t;
        if (exp_q[who].size() == 0) begin
            $display("%s returned read data with no read outstanding, cycle %0d",
                     names[who], cycle);
            errors++;
        end else begin
            e = exp_q[who].pop_front();
            t = t_q[who].pop_front();
            checks++;
            if (act !== e) begin
                $display("[FAIL] %s: %s read expected %h actual %h",
                         test_name, names[who], e, act);
                errors++;
            end
            if (cycle - t != 4) begin
                $display("[FAIL] %s: %s read latency expected 4 actual %0d",
                         test_name, names[who], cycle - t);
                errors++;
            end
        end
    endtask

    // grants update the shadow and reads queue their expected data
    always @(posedge fclk) begin : compare
        logic [DATA_W-1:0] w;
        int k;
        if (!rst) begin
            cycle = cycle + 1;
            for (k = 0; k < 3; k++) begin
                if (rvalids[k]) begin
                    check_return(k, rdatas[k]);
                end
            end
            if ($countones(readies) > 1) begin
                $display("more than one ready in cycle %0d (%b)", cycle, readies);
                errors++;
            end
            if (video_ready) begin
                exp_q[VID].push_back(ref_word(video_addr));
                t_q[VID].push_back(cycle);
            end
            if (cpu_ready && cpu_op == OP_WRITE) begin
                w = shadow[cpu_addr[WA:1]];
                if (cpu_addr[0]) begin
                    w[DATA_W-1:BYTE_W] = cpu_wdata;
                end else begin
                    w[BYTE_W-1:0] = cpu_wdata;
                end
                shadow[cpu_addr[WA:1]] = w;
            end else if (cpu_ready) begin
                exp_q[CPU].push_back({{(DATA_W-BYTE_W){1'b0}}, ref_byte(cpu_addr)});
                t_q[CPU].push_back(cycle);
            end
            if (dma_ready && dma_op == OP_WRITE) begin
                shadow[dma_addr] = dma_wdata;
            end else if (dma_ready) begin
                exp_q[DMA].push_back(ref_word(dma_addr));
                t_q[DMA].push_back(cycle);
            end
            for (k = 0; k < 3; k++) begin
                if (readies[k]) begin
                    grant_log.push_back(k);
                    grant_cyc.push_back(cycle);
                end
            end
        end
    end

    // addr is a byte address for the cpu and a word address for the others
    task automatic request(input int who, input dram_op_t op, input logic [WA:0] addr,
                           input logic [DATA_W-1:0] wdata);
        case (who)
            VID: begin
                video_addr  = addr[WA-1:0];
                video_valid = 1'b1;
            end
            CPU: begin
                cpu_op    = op;
                cpu_addr  = addr;
                cpu_wdata = wdata[BYTE_W-1:0];
                cpu_valid = 1'b1;
            end
            default: begin
                dma_op    = op;
                dma_addr  = addr[WA-1:0];
                dma_wdata = wdata;
                dma_valid = 1'b1;
            end
        endcase
        do @(posedge fclk); while (!readies[who]);
        #1;
        case (who)
            VID: video_valid = 1'b0;
            CPU: cpu_valid = 1'b0;
            default: dma_valid = 1'b0;
        endcase
    endtask

    task automatic traffic(input int who, input int n);
        int gap;
        logic [WA:0] addr;
        repeat (n) begin
            // gaps longer than a slot let the lower priorities in
            gap = $urandom % 8;
            repeat (gap) begin
                @(posedge fclk);
                #1;
            end
            addr = {1'b0, pool[$urandom % POOL_N]};
            if (who == CPU) begin
                addr = {pool[$urandom % POOL_N], 1'($urandom)};
            end
            request(who, (who != VID && $urandom % 2 == 1) ? OP_WRITE : OP_READ, addr,
                    16'($urandom));
        end
    endtask

    task automatic wait_idle();
        while (exp_q[VID].size() + exp_q[CPU].size() + exp_q[DMA].size() != 0) begin
            @(posedge fclk);
        end
        // let a trailing write slot finish
        repeat (4) @(posedge fclk);
        #1;
    endtask

    initial begin : stimulus
        int i;
        int log_start;
        void'($urandom(32'h5420));
        rst         = 1'b1;
        video_valid = 1'b0;
        video_addr  = '0;
        cpu_valid   = 1'b0;
        cpu_op      = OP_READ;
        cpu_addr    = '0;
        cpu_wdata   = '0;
        dma_valid   = 1'b0;
        dma_op      = OP_READ;
        dma_addr    = '0;
        dma_wdata   = '0;
        repeat (16) @(posedge fclk);
        #1;
        rst = 1'b0;

        test_name = "reset";
        repeat (8) begin
            if ({readies, rvalids} !== 6'b0) begin
                $display("[FAIL] %s: ready/rvalid expected 000000 actual %b",
                         test_name, {readies, rvalids});
                stim_errors++;
            end
            if ({rras0_n, rras1_n, rucas_n, rlcas_n, rwe_n} !== 5'b11111) begin
                $display("[FAIL] %s: strobes expected 11111 actual %b", test_name,
                         {rras0_n, rras1_n, rucas_n, rlcas_n, rwe_n});
                stim_errors++;
            end
            @(posedge fclk);
            #1;
        end

        // word pool in alternating banks
        test_name = "preload";
        for (i = 0; i < POOL_N; i++) begin
            pool[i] = {i[0], RA2'($urandom)};
            request(DMA, OP_WRITE, {1'b0, pool[i]}, 16'($urandom));
        end
        wait_idle();

        test_name = "dma word";
        request(DMA, OP_WRITE, {1'b0, pool[0]}, 16'h1234);
        request(DMA, OP_READ, {1'b0, pool[0]}, 16'h0);
        wait_idle();

        test_name = "cpu byte";
        request(DMA, OP_WRITE, {1'b0, pool[1]}, 16'h5678);
        request(CPU, OP_WRITE, {pool[1], 1'b1}, 16'h00ab);
        request(DMA, OP_READ, {1'b0, pool[1]}, 16'h0);
        request(CPU, OP_READ, {pool[1], 1'b0}, 16'h0);
        request(CPU, OP_READ, {pool[1], 1'b1}, 16'h0);
        wait_idle();

        test_name = "priority";
        log_start = grant_log.size();
        fork
            request(VID, OP_READ, {1'b0, pool[2]}, 16'h0);
            request(CPU, OP_READ, {pool[3], 1'b0}, 16'h0);
            request(DMA, OP_READ, {1'b0, pool[4]}, 16'h0);
        join
        wait_idle();
        if (grant_log.size() != log_start + 3) begin
            $display("priority test saw %0d grants instead of 3", grant_log.size() - log_start);
            stim_errors++;
        end else begin
            for (i = 0; i < 3; i++) begin
                if (grant_log[log_start + i] != i) begin
                    $display("[FAIL] %s: grant %0d expected %s actual %s", test_name, i,
                             names[i], names[grant_log[log_start + i]]);
                    stim_errors++;
                end
                if (i > 0 && grant_cyc[log_start + i] - grant_cyc[log_start + i - 1] != 4) begin
                    $display("[FAIL] %s: grant spacing expected 4 actual %0d", test_name,
                             grant_cyc[log_start + i] - grant_cyc[log_start + i - 1]);
                    stim_errors++;
                end
            end
        end

        test_name = "random";
        fork
            traffic(VID, RAND_N / 3);
            traffic(CPU, RAND_N / 3);
            traffic(DMA, RAND_N / 3);
        join
        wait_idle();

        $display("checks %0d, errors %0d", checks, errors + stim_errors);
        if (errors + stim_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (TIMEOUT) @(posedge fclk);
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/dram_model.sv */
`timescale 1ns/1ps
`default_nettype none

module dram_model
    import zx_dram_pkg::*;
#(
    parameter int RA_W = 10
) (
    input  logic                fclk,
    input  logic [RA_W-1:0]     ra,
    input  logic [DATA_W-1:0]   dram_wd,
    output logic [DATA_W-1:0]   dram_rd,
    input  logic                rwe_n,
    input  logic                rucas_n,
    input  logic                rlcas_n,
    input  logic                rras0_n,
    input  logic                rras1_n
);

    localparam int KW = 2*RA_W + 1;

    logic [DATA_W-1:0] mem [logic [KW-1:0]];
    logic              bank;
    logic [RA_W-1:0]   row;
    logic [KW-1:0]     key;

    // untouched words read back a pattern of their full address
    function automatic logic [DATA_W-1:0] fill(input logic [KW-1:0] k);
        return DATA_W'(k ^ (k >> 5)) ^ 16'h5a3c;
    endfunction

    assign key = {bank, row, ra};

    always_comb begin
        if (!rucas_n || !rlcas_n) begin
            dram_rd = mem.exists(key) ? mem[key] : fill(key);
        end else begin
            dram_rd = '0;
        end
    end

    always @(posedge fclk) begin : port
        logic [DATA_W-1:0] w;
        // row is on ra while RAS is low and both CAS are high
        if ((!rras0_n || !rras1_n) && rucas_n && rlcas_n) begin
            bank <= !rras1_n;
            row  <= ra;
        end
        if (!rwe_n && (!rucas_n || !rlcas_n)) begin
            w = mem.exists(key) ? mem[key] : fill(key);
            if (!rucas_n) begin
                w[DATA_W-1:BYTE_W] = dram_wd[DATA_W-1:BYTE_W];
            end
            if (!rlcas_n) begin
                w[BYTE_W-1:0] = dram_wd[BYTE_W-1:0];
            end
            mem[key] = w;
        end
    end

endmodule

`default_nettype wire

/* source/zx_dram_top.sv */
`timescale 1ns/1ps
`default_nettype none

module zx_dram_top
    import zx_dram_pkg::*;
#(
    parameter int RA_W = 10
) (
    input  logic                fclk,
    input  logic                rst,

    input  logic                video_valid,
    input  logic [2*RA_W:0]     video_addr,
    output logic                video_ready,
    output logic                video_rvalid,
    output logic [DATA_W-1:0]   video_rdata,

    input  logic                cpu_valid,
    input  dram_op_t            cpu_op,
    input  logic [2*RA_W+1:0]   cpu_addr,
    input  logic [BYTE_W-1:0]   cpu_wdata,
    output logic                cpu_ready,
    output logic                cpu_rvalid,
    output logic [BYTE_W-1:0]   cpu_rdata,

    input  logic                dma_valid,
    input  dram_op_t            dma_op,
    input  logic [2*RA_W:0]     dma_addr,
    input  logic [DATA_W-1:0]   dma_wdata,
    output logic                dma_ready,
    output logic                dma_rvalid,
    output logic [DATA_W-1:0]   dma_rdata,

    output logic [RA_W-1:0]     ra,
    output logic [DATA_W-1:0]   dram_wd,
    input  logic [DATA_W-1:0]   dram_rd,
    output logic                rwe_n,
    output logic                rucas_n,
    output logic                rlcas_n,
    output logic                rras0_n,
    output logic                rras1_n
);

    dram_phase_t         phase;
    logic                acc_start;
    dram_op_t            acc_op;
    logic [2*RA_W:0]     acc_addr;
    logic [DATA_W-1:0]   acc_wdata;
    logic [1:0]          acc_bsel;
    logic [DATA_W-1:0]   acc_rdata;
    logic                acc_rdone;

    dram_arbiter #(
        .RA_W(RA_W)
    ) arbiter (
        .fclk        (fclk),
        .rst         (rst),
        .video_valid (video_valid),
        .video_addr  (video_addr),
        .video_ready (video_ready),
        .video_rvalid(video_rvalid),
        .video_rdata (video_rdata),
        .cpu_valid   (cpu_valid),
        .cpu_op      (cpu_op),
        .cpu_addr    (cpu_addr),
        .cpu_wdata   (cpu_wdata),
        .cpu_ready   (cpu_ready),
        .cpu_rvalid  (cpu_rvalid),
        .cpu_rdata   (cpu_rdata),
        .dma_valid   (dma_valid),
        .dma_op      (dma_op),
        .dma_addr    (dma_addr),
        .dma_wdata   (dma_wdata),
        .dma_ready   (dma_ready),
        .dma_rvalid  (dma_rvalid),
        .dma_rdata   (dma_rdata),
        .phase       (phase),
        .acc_start   (acc_start),
        .acc_op      (acc_op),
        .acc_addr    (acc_addr),
        .acc_wdata   (acc_wdata),
        .acc_bsel    (acc_bsel),
        .acc_rdata   (acc_rdata),
        .acc_rdone   (acc_rdone)
    );

    dram_sequencer #(
        .RA_W(RA_W)
    ) sequencer (
        .fclk     (fclk),
        .rst      (rst),
        .phase    (phase),
        .acc_start(acc_start),
        .acc_op   (acc_op),
        .acc_addr (acc_addr),
        .acc_wdata(acc_wdata),
        .acc_bsel (acc_bsel),
        .acc_rdata(acc_rdata),
        .acc_rdone(acc_rdone),
        .ra       (ra),
        .dram_wd  (dram_wd),
        .dram_rd  (dram_rd),
        .rwe_n    (rwe_n),
        .rucas_n  (rucas_n),
        .rlcas_n  (rlcas_n),
        .rras0_n  (rras0_n),
        .rras1_n  (rras1_n)
    );

endmodule

`default_nettype wire

/* source/dram_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module dram_sequencer
    import zx_dram_pkg::*;
#(
    parameter int RA_W = 10
) (
    input  logic                fclk,
    input  logic                rst,

    input  dram_phase_t         phase,
    input  logic                acc_start,
    input  dram_op_t            acc_op,
    input  logic [2*RA_W:0]     acc_addr,
    input  logic [DATA_W-1:0]   acc_wdata,
    input  logic [1:0]          acc_bsel,
    output logic [DATA_W-1:0]   acc_rdata,
    output logic                acc_rdone,

    output logic [RA_W-1:0]     ra,
    output logic [DATA_W-1:0]   dram_wd,
    input  logic [DATA_W-1:0]   dram_rd,
    output logic                rwe_n,
    output logic                rucas_n,
    output logic                rlcas_n,
    output logic                rras0_n,
    output logic                rras1_n
);

    logic            busy;
    logic            is_wr;
    logic [1:0]      bsel;
    logic [RA_W-1:0] col;

    // strobes and slot tracking
    always_ff @(posedge fclk) begin
        if (rst) begin
            busy      <= 1'b0;
            acc_rdone <= 1'b0;
            rras0_n   <= 1'b1;
            rras1_n   <= 1'b1;
            rucas_n   <= 1'b1;
            rlcas_n   <= 1'b1;
            rwe_n     <= 1'b1;
        end else begin
            acc_rdone <= 1'b0;
            case (phase)
                PH_RAS: begin
                    if (acc_start) begin
                        busy <= 1'b1;
                        // top address bit picks the bank
                        rras0_n <= acc_addr[2*RA_W];
                        rras1_n <= !acc_addr[2*RA_W];
                    end
                end
                PH_CAS: begin
                    if (busy) begin
                        rucas_n <= !bsel[1];
                        rlcas_n <= !bsel[0];
                        rwe_n   <= !is_wr;
                    end
                end
                PH_DATA: begin
                    if (busy && !is_wr) begin
                        acc_rdone <= 1'b1;
                    end
                end
                PH_END: begin
                    busy    <= 1'b0;
                    rras0_n <= 1'b1;
                    rras1_n <= 1'b1;
                    rucas_n <= 1'b1;
                    rlcas_n <= 1'b1;
                    rwe_n   <= 1'b1;
                end
                default: begin
                    busy <= 1'b0;
                end
            endcase
        end
    end

    // address mux and data path
    always_ff @(posedge fclk) begin
        if (phase == PH_RAS && acc_start) begin
            ra      <= acc_addr[2*RA_W-1:RA_W];
            col     <= acc_addr[RA_W-1:0];
            bsel    <= acc_bsel;
            is_wr   <= (acc_op == OP_WRITE);
            dram_wd <= acc_wdata;
        end else if (phase == PH_CAS && busy) begin
            ra <= col;
        end

        // dram_rd is valid while CAS is low
        if (phase == PH_DATA && busy && !is_wr) begin
            acc_rdata <= dram_rd;
        end
    end

    cas_after_ras: assert property (@(posedge fclk) disable iff (rst)
        (!rucas_n || !rlcas_n) |-> (!rras0_n || !rras1_n) && $past(!rras0_n || !rras1_n));

    one_bank: assert property (@(posedge fclk) disable iff (rst)
        !(!rras0_n && !rras1_n));

endmodule

`default_nettype wire

/* source/dram_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module dram_arbiter
    import zx_dram_pkg::*;
#(
    parameter int RA_W = 10
) (
    input  logic                fclk,
    input  logic                rst,

    input  logic                video_valid,
    input  logic [2*RA_W:0]     video_addr,
    output logic                video_ready,
    output logic                video_rvalid,
    output logic [DATA_W-1:0]   video_rdata,

    input  logic                cpu_valid,
    input  dram_op_t            cpu_op,
    input  logic [2*RA_W+1:0]   cpu_addr,
    input  logic [BYTE_W-1:0]   cpu_wdata,
    output logic                cpu_ready,
    output logic                cpu_rvalid,
    output logic [BYTE_W-1:0]   cpu_rdata,

    input  logic                dma_valid,
    input  dram_op_t            dma_op,
    input  logic [2*RA_W:0]     dma_addr,
    input  logic [DATA_W-1:0]   dma_wdata,
    output logic                dma_ready,
    output logic                dma_rvalid,
    output logic [DATA_W-1:0]   dma_rdata,

    output dram_phase_t         phase,
    output logic                acc_start,
    output dram_op_t            acc_op,
    output logic [2*RA_W:0]     acc_addr,
    output logic [DATA_W-1:0]   acc_wdata,
    output logic [1:0]          acc_bsel,
    input  logic [DATA_W-1:0]   acc_rdata,
    input  logic                acc_rdone
);

    logic        slot_end;
    dram_owner_t owner;
    logic        cpu_lane;

    always_ff @(posedge fclk) begin
        if (rst) begin
            phase <= PH_RAS;
        end else begin
            phase <= dram_phase_t'(phase + 2'd1);
        end
    end

    assign slot_end = (phase == PH_END);

    // fixed priority with video first and dma last
    assign video_ready = slot_end && video_valid;
    assign cpu_ready   = slot_end && cpu_valid && !video_valid;
    assign dma_ready   = slot_end && dma_valid && !video_valid && !cpu_valid;

    always_ff @(posedge fclk) begin
        if (rst) begin
            acc_start <= 1'b0;
            owner     <= OWN_NONE;
        end else if (slot_end) begin
            acc_start <= video_ready || cpu_ready || dma_ready;
            if (video_ready) begin
                owner <= OWN_VIDEO;
            end else if (cpu_ready) begin
                owner <= OWN_CPU;
            end else if (dma_ready) begin
                owner <= OWN_DMA;
            end else begin
                owner <= OWN_NONE;
            end
        end else begin
            acc_start <= 1'b0;
        end
    end

    // access payload is held for the whole next slot
    always_ff @(posedge fclk) begin
        if (video_ready) begin
            acc_op   <= OP_READ;
            acc_addr <= video_addr;
            acc_bsel <= 2'b11;
        end else if (cpu_ready) begin
            acc_op    <= cpu_op;
            acc_addr  <= cpu_addr[2*RA_W+1:1];
            // same byte on both halves and CAS picks the lane
            acc_wdata <= {cpu_wdata, cpu_wdata};
            cpu_lane  <= cpu_addr[0];
            if (cpu_op == OP_WRITE) begin
                acc_bsel <= cpu_addr[0] ? 2'b10 : 2'b01;
            end else begin
                acc_bsel <= 2'b11;
            end
        end else if (dma_ready) begin
            acc_op    <= dma_op;
            acc_addr  <= dma_addr;
            acc_wdata <= dma_wdata;
            acc_bsel  <= 2'b11;
        end
    end

    // owner stays valid until the end of PH_END
    assign video_rvalid = acc_rdone && (owner == OWN_VIDEO);
    assign cpu_rvalid   = acc_rdone && (owner == OWN_CPU);
    assign dma_rvalid   = acc_rdone && (owner == OWN_DMA);

    assign video_rdata = acc_rdata;
    assign dma_rdata   = acc_rdata;
    // odd byte address lives in the upper half
    assign cpu_rdata   = cpu_lane ? acc_rdata[BYTE_W +: BYTE_W] : acc_rdata[0 +: BYTE_W];

    one_ready: assert property (@(posedge fclk) disable iff (rst)
        $onehot0({video_ready, cpu_ready, dma_ready}));

    ready_at_end: assert property (@(posedge fclk) disable iff (rst)
        (video_ready || cpu_ready || dma_ready) |-> (phase == PH_END));

    // read data must come back in the slot after the grant
    rdone_owned: assert property (@(posedge fclk) disable iff (rst)
        acc_rdone |-> (phase == PH_END) && (owner != OWN_NONE) && $past(acc_start, 3));

endmodule

`default_nettype wire

/* source/zx_dram_pkg.sv */
`default_nettype none

package zx_dram_pkg;

    localparam int DATA_W = 16;
    localparam int BYTE_W = 8;

    // four fclk cycles of one DRAM slot
    typedef enum logic [1:0] {
        PH_RAS  = 2'd0,
        PH_CAS  = 2'd1,
        PH_DATA = 2'd2,
        PH_END  = 2'd3
    } dram_phase_t;

    // owner of the access in flight
    typedef enum logic [1:0] {
        OWN_NONE  = 2'd0,
        OWN_VIDEO = 2'd1,
        OWN_CPU   = 2'd2,
        OWN_DMA   = 2'd3
    } dram_owner_t;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } dram_op_t;

endpackage

`default_nettype wire
